//--- source/srcPkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths, field positions and IR views
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package srcPkg;

	localparam int dataWidth = 32; // Bus and register width
	localparam int registerCount = 16; // General registers R0..R15

	// Instruction word field positions
	localparam int opcodeMsb = 31;
	localparam int opcodeLsb = 27;
	localparam int raMsb = 26;
	localparam int raLsb = 23;
	localparam int rbMsb = 22;
	localparam int rbLsb = 19;
	localparam int rcMsb = 18; // rc shares the top of the constant field
	localparam int rcLsb = 15;
	localparam int constantMsb = 18;
	localparam int constantLsb = 0;
	localparam int constantWidth = constantMsb - constantLsb + 1;

	// Opcodes of the kept instructions
	localparam logic [opcodeMsb-opcodeLsb:0] opLd = 5'b00000;
	localparam logic [opcodeMsb-opcodeLsb:0] opLdi = 5'b00001;
	localparam logic [opcodeMsb-opcodeLsb:0] opSt = 5'b00010;
	localparam logic [opcodeMsb-opcodeLsb:0] opAdd = 5'b00011;
	localparam logic [opcodeMsb-opcodeLsb:0] opSub = 5'b00100;
	localparam logic [opcodeMsb-opcodeLsb:0] opShr = 5'b00101;
	localparam logic [opcodeMsb-opcodeLsb:0] opShl = 5'b00111;
	localparam logic [opcodeMsb-opcodeLsb:0] opAnd = 5'b01010;
	localparam logic [opcodeMsb-opcodeLsb:0] opOr = 5'b01011;
	localparam logic [opcodeMsb-opcodeLsb:0] opNeg = 5'b10000;
	localparam logic [opcodeMsb-opcodeLsb:0] opNot = 5'b10001;
	localparam logic [opcodeMsb-opcodeLsb:0] opBranch = 5'b10010;

	// Branch condition codes, found in the rb slot
	localparam logic [rbMsb-rbLsb:0] condZero = 4'd0;
	localparam logic [rbMsb-rbLsb:0] condNonzero = 4'd1;
	localparam logic [rbMsb-rbLsb:0] condPositive = 4'd2;
	localparam logic [rbMsb-rbLsb:0] condNegative = 4'd3;

	typedef struct packed {
		logic [opcodeMsb-opcodeLsb:0] opcode;
		logic [raMsb-raLsb:0] ra;
		logic [rbMsb-rbLsb:0] rb;
		logic [constantMsb-constantLsb:0] constant; // Also carries rc
	} generalView;

	typedef struct packed {
		logic [opcodeMsb-opcodeLsb:0] opcode;
		logic [raMsb-raLsb:0] ra;
		logic [rbMsb-rbLsb:0] cond;
		logic [constantMsb-constantLsb:0] unused;
	} branchView;

	// One IR word, read as ALU/memory format or as branch format
	typedef union packed {
		generalView general;
		branchView branch;
	} instructionWord;

endpackage

`default_nettype wire

//--- source/selectEncode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register select decode and constant sign extension
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module selectEncode (
	input srcPkg::instructionWord instruction,
	input logic Gra,
	input logic Grb,
	input logic Grc,
	input logic Rin,
	input logic Rout,
	input logic BAout,
	output logic [srcPkg::registerCount-1:0] writeSelect,
	output logic [srcPkg::registerCount-1:0] readSelect,
	output logic [srcPkg::dataWidth-1:0] constantExtended
);

	localparam int fieldWidth = srcPkg::raMsb - srcPkg::raLsb + 1;
	localparam int extendWidth = srcPkg::dataWidth - srcPkg::constantWidth;

	logic [fieldWidth-1:0] rcField;
	logic [fieldWidth-1:0] fieldSelected; // Register number picked by Gr strobes
	logic [srcPkg::registerCount-1:0] decoded;
	logic constantSign;

	// rc lives in the upper bits of the constant field
	assign rcField = instruction[srcPkg::rcMsb:srcPkg::rcLsb];

	// Gr strobes are exclusive, so a plain AND-OR is enough
	assign fieldSelected = ({fieldWidth{Gra}} & instruction.general.ra)
		| ({fieldWidth{Grb}} & instruction.general.rb)
		| ({fieldWidth{Grc}} & rcField);

	// 4-to-16 one-hot
	always_comb begin
		decoded = '0;
		decoded[fieldSelected] = 1'b1;
	end

	assign writeSelect = Rin ? decoded : '0; // Only one register loads, and only under Rin
	assign readSelect = (Rout | BAout) ? decoded : '0;

	// Sign extension of C for CSEout
	assign constantSign = instruction.general.constant[srcPkg::constantWidth-1];
	assign constantExtended = {{extendWidth{constantSign}}, instruction.general.constant};

endmodule

`default_nettype wire

//--- source/registerFile.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sixteen general registers on the shared bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module registerFile (
	input logic clock,
	input logic reset,
	input logic [srcPkg::registerCount-1:0] writeSelect,
	input logic [srcPkg::registerCount-1:0] readSelect,
	input logic BAout,
	input logic [srcPkg::dataWidth-1:0] busData,
	output logic [srcPkg::dataWidth-1:0] readData
);

	logic [srcPkg::dataWidth-1:0] registers [srcPkg::registerCount];

	// Bus write into the one-hot selected register
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < srcPkg::registerCount; i++)
				registers[i] <= '0;
		end else begin
			for (int i = 0; i < srcPkg::registerCount; i++)
				if (writeSelect[i])
					registers[i] <= busData;
		end
	end

	// One-hot read, OR of the selected word
	always_comb begin
		readData = '0;
		for (int i = 0; i < srcPkg::registerCount; i++)
			if (readSelect[i])
				readData = readData | registers[i];
		// R0 as a base reads zero, giving absolute addressing
		if (BAout && readSelect[0])
			readData = '0;
	end

endmodule

`default_nettype wire

//--- source/arithUnit.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ALU with the Y operand and Z result registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module arithUnit (
	input logic clock,
	input logic reset,
	input logic [srcPkg::dataWidth-1:0] busData,
	input logic Yin,
	input logic Zlowin,
	input logic ADD,
	input logic SUB,
	input logic AND,
	input logic OR,
	input logic NEG,
	input logic NOT,
	input logic SHR,
	input logic SHL,
	input logic IncPC,
	output logic [srcPkg::dataWidth-1:0] zData
);

	localparam int shiftWidth = $clog2(srcPkg::dataWidth);

	logic [srcPkg::dataWidth-1:0] yReg; // First operand
	logic [srcPkg::dataWidth-1:0] zReg;
	logic [srcPkg::dataWidth-1:0] result;
	logic [shiftWidth-1:0] shiftAmount;

	assign shiftAmount = busData[shiftWidth-1:0]; // Low five bits of the bus

	always_ff @(posedge clock) begin
		if (reset)
			yReg <= '0;
		else if (Yin)
			yReg <= busData;
	end

	// At most one op strobe per step, IncPC first for the fetch
	always_comb begin
		if (IncPC)
			result = busData + 1'b1;
		else if (ADD)
			result = yReg + busData;
		else if (SUB)
			result = yReg - busData;
		else if (AND)
			result = yReg & busData;
		else if (OR)
			result = yReg | busData;
		else if (SHR)
			result = yReg >> shiftAmount; // Logical
		else if (SHL)
			result = yReg << shiftAmount;
		else if (NEG)
			result = -busData; // Unary ops take the bus alone
		else if (NOT)
			result = ~busData;
		else
			result = busData; // Pass-through
	end

	always_ff @(posedge clock) begin
		if (reset)
			zReg <= '0;
		else if (Zlowin)
			zReg <= result;
	end

	assign zData = zReg;

endmodule

`default_nettype wire

//--- source/memoryInterface.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MAR, MDR and the word-addressed RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module memoryInterface #(
	parameter int ramAddressWidth = 9
) (
	input logic clock,
	input logic reset,
	input logic [srcPkg::dataWidth-1:0] busData,
	input logic MARin,
	input logic MDRin,
	input logic MDMuxread,
	input logic RAMread,
	input logic RAMwrite,
	output logic [srcPkg::dataWidth-1:0] mdrData
);

	localparam int ramDepth = 1 << ramAddressWidth;

	logic [ramAddressWidth-1:0] marReg;
	logic [srcPkg::dataWidth-1:0] mdrReg;
	logic [srcPkg::dataWidth-1:0] ram [ramDepth];
	logic [srcPkg::dataWidth-1:0] ramReadData;
	logic [srcPkg::dataWidth-1:0] mdrNext;

	// MAR keeps only the word address bits
	always_ff @(posedge clock) begin
		if (reset)
			marReg <= '0;
		else if (MARin)
			marReg <= busData[ramAddressWidth-1:0];
	end

	assign ramReadData = RAMread ? ram[marReg] : '0; // Asynchronous read at MAR

	// MDR input mux between bus and RAM
	assign mdrNext = MDMuxread ? ramReadData : busData;

	always_ff @(posedge clock) begin
		if (reset)
			mdrReg <= '0;
		else if (MDRin)
			mdrReg <= mdrNext;
	end

	// Store MDR at MAR, only word 0 comes out of reset cleared
	always_ff @(posedge clock) begin
		if (reset)
			ram[0] <= '0;
		else if (RAMwrite)
			ram[marReg] <= mdrReg;
	end

	assign mdrData = mdrReg;

endmodule

`default_nettype wire

//--- source/conditionFlag.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Branch condition test and CON flip-flop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module conditionFlag (
	input logic clock,
	input logic reset,
	input srcPkg::instructionWord instruction,
	input logic [srcPkg::dataWidth-1:0] busData,
	input logic CONin,
	output logic conFF
);

	logic busZero;
	logic busNegative;
	logic conditionMet;
	logic conReg;

	assign busZero = (busData == '0);
	assign busNegative = busData[srcPkg::dataWidth-1]; // Sign bit

	// cond sits in the rb slot of the branch view
	always_comb begin
		case (instruction.branch.cond)
			srcPkg::condZero: conditionMet = busZero;
			srcPkg::condNonzero: conditionMet = !busZero;
			srcPkg::condPositive: conditionMet = !busNegative && !busZero;
			srcPkg::condNegative: conditionMet = busNegative;
			default: conditionMet = 1'b0; // Unknown code never branches
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset)
			conReg <= 1'b0;
		else if (CONin)
			conReg <= conditionMet;
	end

	assign conFF = conReg;

endmodule

`default_nettype wire

//--- source/datapath.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Strobe-driven 32-bit datapath on one shared bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module datapath #(
	parameter int ramAddressWidth = 9
) (
	input logic clock,
	input logic reset,
	// Bus drivers
	input logic PCout,
	input logic MDRout,
	input logic Zlowout,
	input logic InPortout,
	input logic CSEout,
	input logic Rout,
	input logic BAout,
	// Register loads
	input logic PCin,
	input logic IRin,
	input logic MARin,
	input logic MDRin,
	input logic Yin,
	input logic Zlowin,
	input logic Rin,
	input logic OutPortin,
	input logic CONin,
	// Memory and register select
	input logic MDMuxread,
	input logic RAMread,
	input logic RAMwrite,
	input logic Gra,
	input logic Grb,
	input logic Grc,
	// ALU ops
	input logic ADD,
	input logic SUB,
	input logic AND,
	input logic OR,
	input logic NEG,
	input logic NOT,
	input logic SHR,
	input logic SHL,
	input logic IncPC,
	input logic [srcPkg::dataWidth-1:0] inPortData,
	output logic [srcPkg::dataWidth-1:0] outPortData,
	output logic conFF
);

	logic [srcPkg::dataWidth-1:0] busData;
	logic [srcPkg::dataWidth-1:0] pcReg;
	srcPkg::instructionWord irReg;
	logic [srcPkg::dataWidth-1:0] outPortReg;
	logic [srcPkg::dataWidth-1:0] registerData;
	logic [srcPkg::dataWidth-1:0] zData;
	logic [srcPkg::dataWidth-1:0] mdrData;
	logic [srcPkg::dataWidth-1:0] constantExtended;
	logic [srcPkg::registerCount-1:0] writeSelect;
	logic [srcPkg::registerCount-1:0] readSelect;

	// Bus mux as AND-OR, zero when nothing drives
	assign busData = ({srcPkg::dataWidth{PCout}} & pcReg)
		| ({srcPkg::dataWidth{MDRout}} & mdrData)
		| ({srcPkg::dataWidth{Zlowout}} & zData)
		| ({srcPkg::dataWidth{InPortout}} & inPortData)
		| ({srcPkg::dataWidth{CSEout}} & constantExtended)
		| ({srcPkg::dataWidth{Rout | BAout}} & registerData);

	// PC, IR and out-port load straight from the bus
	always_ff @(posedge clock) begin
		if (reset) begin
			pcReg <= '0;
			irReg <= '0;
			outPortReg <= '0;
		end else begin
			if (PCin)
				pcReg <= busData;
			if (IRin)
				irReg <= busData;
			if (OutPortin)
				outPortReg <= busData;
		end
	end

	assign outPortData = outPortReg;

	selectEncode selectEncode_inst (
		.instruction(irReg),
		.Gra(Gra),
		.Grb(Grb),
		.Grc(Grc),
		.Rin(Rin),
		.Rout(Rout),
		.BAout(BAout),
		.writeSelect(writeSelect),
		.readSelect(readSelect),
		.constantExtended(constantExtended)
	);

	registerFile registerFile_inst (
		.clock(clock),
		.reset(reset),
		.writeSelect(writeSelect),
		.readSelect(readSelect),
		.BAout(BAout),
		.busData(busData),
		.readData(registerData)
	);

	arithUnit arithUnit_inst (
		.clock(clock),
		.reset(reset),
		.busData(busData),
		.Yin(Yin),
		.Zlowin(Zlowin),
		.ADD(ADD),
		.SUB(SUB),
		.AND(AND),
		.OR(OR),
		.NEG(NEG),
		.NOT(NOT),
		.SHR(SHR),
		.SHL(SHL),
		.IncPC(IncPC),
		.zData(zData)
	);

	memoryInterface #(
		.ramAddressWidth(ramAddressWidth)
	) memoryInterface_inst (
		.clock(clock),
		.reset(reset),
		.busData(busData),
		.MARin(MARin),
		.MDRin(MDRin),
		.MDMuxread(MDMuxread),
		.RAMread(RAMread),
		.RAMwrite(RAMwrite),
		.mdrData(mdrData)
	);

	// Flag tests the bus under the IR's cond
	conditionFlag conditionFlag_inst (
		.clock(clock),
		.reset(reset),
		.instruction(irReg),
		.busData(busData),
		.CONin(CONin),
		.conFF(conFF)
	);

endmodule

`default_nettype wire

//--- dv/datapath_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bus, Z and RAM assertions bound into the datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module datapath_checker (
	input logic clock,
	input logic reset,
	input logic PCout,
	input logic MDRout,
	input logic Zlowout,
	input logic InPortout,
	input logic CSEout,
	input logic Rout,
	input logic BAout,
	input logic Zlowin,
	input logic MARin,
	input logic RAMwrite,
	input logic [31:0] busData,
	input logic [31:0] zData,
	input logic [31:0] ramAtMar // RAM word currently addressed by MAR
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [6:0] outStrobes;

	assign outStrobes = {PCout, MDRout, Zlowout, InPortout, CSEout, Rout, BAout};

	busDriverOnehot: assert property (@(posedge clock) disable iff (reset)
		$onehot0(outStrobes))
		else $error("More than one bus driver strobe is high");

	busIdleZero: assert property (@(posedge clock) disable iff (reset)
		!(|outStrobes) |-> busData == '0)
		else $error("Bus is not zero with no driver strobe");

	// Z holds unless loaded
	zHoldsWithoutLoad: assert property (@(posedge clock) disable iff (reset)
		!Zlowin |=> zData === $past(zData))
		else $error("Z changed without Zlowin");

	ramHoldsWithoutWrite: assert property (@(posedge clock) disable iff (reset)
		!RAMwrite && !MARin |=> ramAtMar === $past(ramAtMar))
		else $error("RAM word at MAR changed without RAMwrite");

endmodule

bind datapath datapath_checker datapath_checker_inst (
	.clock(clock),
	.reset(reset),
	.PCout(PCout),
	.MDRout(MDRout),
	.Zlowout(Zlowout),
	.InPortout(InPortout),
	.CSEout(CSEout),
	.Rout(Rout),
	.BAout(BAout),
	.Zlowin(Zlowin),
	.MARin(MARin),
	.RAMwrite(RAMwrite),
	.busData(busData),
	.zData(zData),
	.ramAtMar(memoryInterface_inst.ram[memoryInterface_inst.marReg])
);

`default_nettype wire

//--- dv/datapathTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath testbench, steps the strobe sequences of random
// programs and checks them against a reference model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module datapathTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int ramAddressWidth = 9;
	localparam int ramDepth = 1 << ramAddressWidth;
	localparam int strobeWidth = 31;
	localparam int ldiCount = 20;
	localparam int stLdCount = 12;
	localparam int aluCount = 32;
	localparam int condCount = 25;
	// Upper bound of clock cycles per test item, summed over the run
	localparam int totalSteps = 8 + ldiCount * 18 + stLdCount * 38 + 16 + aluCount * 22
		+ condCount * 5 + 4;

	typedef logic [srcPkg::dataWidth-1:0] word;
	typedef logic [strobeWidth-1:0] strobeVec;

	// One bit per DUT strobe
	localparam strobeVec pcOut = strobeVec'(1) << 0;
	localparam strobeVec mdrOut = strobeVec'(1) << 1;
	localparam strobeVec zLowOut = strobeVec'(1) << 2;
	localparam strobeVec inPortOut = strobeVec'(1) << 3;
	localparam strobeVec cseOut = strobeVec'(1) << 4;
	localparam strobeVec rOut = strobeVec'(1) << 5;
	localparam strobeVec baOut = strobeVec'(1) << 6;
	localparam strobeVec pcIn = strobeVec'(1) << 7;
	localparam strobeVec irIn = strobeVec'(1) << 8;
	localparam strobeVec marIn = strobeVec'(1) << 9;
	localparam strobeVec mdrIn = strobeVec'(1) << 10;
	localparam strobeVec yIn = strobeVec'(1) << 11;
	localparam strobeVec zLowIn = strobeVec'(1) << 12;
	localparam strobeVec rIn = strobeVec'(1) << 13;
	localparam strobeVec outPortIn = strobeVec'(1) << 14;
	localparam strobeVec conIn = strobeVec'(1) << 15;
	localparam strobeVec mdMuxRead = strobeVec'(1) << 16;
	localparam strobeVec ramRead = strobeVec'(1) << 17;
	localparam strobeVec ramWrite = strobeVec'(1) << 18;
	localparam strobeVec gra = strobeVec'(1) << 19;
	localparam strobeVec grb = strobeVec'(1) << 20;
	localparam strobeVec grc = strobeVec'(1) << 21;
	localparam strobeVec aluAdd = strobeVec'(1) << 22;
	localparam strobeVec aluSub = strobeVec'(1) << 23;
	localparam strobeVec aluAnd = strobeVec'(1) << 24;
	localparam strobeVec aluOr = strobeVec'(1) << 25;
	localparam strobeVec aluNeg = strobeVec'(1) << 26;
	localparam strobeVec aluNot = strobeVec'(1) << 27;
	localparam strobeVec aluShr = strobeVec'(1) << 28;
	localparam strobeVec aluShl = strobeVec'(1) << 29;
	localparam strobeVec incPc = strobeVec'(1) << 30;

	logic clock;
	logic reset;
	strobeVec strobes; // Strobes of the current step
	word inPortData;
	word outPortData;
	logic conFF;

	word regModel [srcPkg::registerCount];
	word ramModel [ramDepth];
	word pcModel;
	int errorCount;
	int checkCount;

	datapath #(
		.ramAddressWidth(ramAddressWidth)
	) datapath_inst (
		.clock(clock),
		.reset(reset),
		.PCout(|(strobes & pcOut)),
		.MDRout(|(strobes & mdrOut)),
		.Zlowout(|(strobes & zLowOut)),
		.InPortout(|(strobes & inPortOut)),
		.CSEout(|(strobes & cseOut)),
		.Rout(|(strobes & rOut)),
		.BAout(|(strobes & baOut)),
		.PCin(|(strobes & pcIn)),
		.IRin(|(strobes & irIn)),
		.MARin(|(strobes & marIn)),
		.MDRin(|(strobes & mdrIn)),
		.Yin(|(strobes & yIn)),
		.Zlowin(|(strobes & zLowIn)),
		.Rin(|(strobes & rIn)),
		.OutPortin(|(strobes & outPortIn)),
		.CONin(|(strobes & conIn)),
		.MDMuxread(|(strobes & mdMuxRead)),
		.RAMread(|(strobes & ramRead)),
		.RAMwrite(|(strobes & ramWrite)),
		.Gra(|(strobes & gra)),
		.Grb(|(strobes & grb)),
		.Grc(|(strobes & grc)),
		.ADD(|(strobes & aluAdd)),
		.SUB(|(strobes & aluSub)),
		.AND(|(strobes & aluAnd)),
		.OR(|(strobes & aluOr)),
		.NEG(|(strobes & aluNeg)),
		.NOT(|(strobes & aluNot)),
		.SHR(|(strobes & aluShr)),
		.SHL(|(strobes & aluShl)),
		.IncPC(|(strobes & incPc)),
		.inPortData(inPortData),
		.outPortData(outPortData),
		.conFF(conFF)
	);

	always #50 clock = ~clock; // 100 ns period

	// Instruction word from its fields
	function automatic word encode(input logic [4:0] op, input logic [3:0] ra,
		input logic [3:0] rb, input logic [18:0] c);
		word w;
		w = '0;
		w[srcPkg::opcodeMsb:srcPkg::opcodeLsb] = op;
		w[srcPkg::raMsb:srcPkg::raLsb] = ra;
		w[srcPkg::rbMsb:srcPkg::rbLsb] = rb;
		w[srcPkg::constantMsb:srcPkg::constantLsb] = c;
		return w;
	endfunction

	function automatic word signExtend(input logic [18:0] c);
		return {{(srcPkg::dataWidth - srcPkg::constantWidth){c[18]}}, c};
	endfunction

	// Reference ALU, y is the Y operand and b the bus operand
	function automatic word aluExpected(input int opIndex, input word y, input word b);
		case (opIndex)
			0: return y + b;
			1: return y - b;
			2: return y & b;
			3: return y | b;
			4: return y << b[4:0];
			5: return y >> b[4:0];
			6: return -b; // Unary ops use the bus alone
			default: return ~b;
		endcase
	endfunction

	function automatic logic condExpected(input logic [3:0] cond, input word value);
		case (cond)
			srcPkg::condZero: return value == '0;
			srcPkg::condNonzero: return value != '0;
			srcPkg::condPositive: return !value[31] && value != '0;
			srcPkg::condNegative: return value[31];
			default: return 1'b0;
		endcase
	endfunction

	// One step, strobes live for one cycle from this rising edge
	task automatic stepData(input strobeVec mask, input word data);
		@(posedge clock);
		strobes <= mask;
		inPortData <= data;
	endtask

	task automatic step(input strobeVec mask);
		stepData(mask, '0);
	endtask

	// Idle step, then sample at the falling edge
	task automatic settle();
		step('0);
		@(negedge clock);
	endtask

	task automatic writeWord(input word address, input word data);
		stepData(inPortOut | marIn, address);
		stepData(inPortOut | mdrIn, data); // MDMuxread low, bus into MDR
		step(ramWrite);
		ramModel[address[ramAddressWidth-1:0]] = data;
	endtask

	task automatic setRegister(input logic [3:0] r, input word value);
		stepData(inPortOut | irIn, encode(srcPkg::opLd, r, 4'd0, 19'd0)); // ra picks r
		stepData(inPortOut | gra | rIn, value);
		regModel[r] = value;
	endtask

	task automatic readRegister(input logic [3:0] r, output word value);
		stepData(inPortOut | irIn, encode(srcPkg::opLd, r, 4'd0, 19'd0));
		step(gra | rOut | outPortIn);
		settle();
		value = outPortData;
	endtask

	// Store at PC, then T0 to T2, then check PC and IR
	task automatic fetchInstruction(input word instruction);
		word oldPc;
		word irSeen;
		oldPc = pcModel;
		writeWord(pcModel, instruction);
		step(pcOut | marIn | incPc | zLowIn);
		step(zLowOut | pcIn | mdMuxRead | ramRead | mdrIn);
		step(mdrOut | irIn);
		pcModel = oldPc + 1;
		step(pcOut | outPortIn);
		settle();
		irSeen = datapath_inst.irReg;
		checkCount += 2;
		if (outPortData !== pcModel) begin
			errorCount++;
			$display("Error at %0t ns: PC after fetch is %h, expected %h", $time, outPortData,
				pcModel);
		end
		if (irSeen !== ramModel[oldPc[ramAddressWidth-1:0]]) begin
			errorCount++;
			$display("Error at %0t ns: IR is %h, expected %h", $time, irSeen,
				ramModel[oldPc[ramAddressWidth-1:0]]);
		end
	endtask

	// Base plus C into Z, R0 as base reads zero
	task automatic addressSteps();
		step(grb | baOut | yIn);
		step(cseOut | aluAdd | zLowIn);
	endtask

	task automatic ldiTest();
		logic [3:0] ra;
		logic [3:0] rb;
		logic [18:0] c;
		word expected;
		word seen;
		ra = 4'($urandom_range(15, 0));
		rb = 4'($urandom_range(15, 0));
		c = 19'($urandom);
		if (rb != 0)
			setRegister(rb, $urandom);
		expected = ((rb == 0) ? '0 : regModel[rb]) + signExtend(c);
		fetchInstruction(encode(srcPkg::opLdi, ra, rb, c));
		addressSteps();
		step(zLowOut | gra | rIn);
		regModel[ra] = expected;
		readRegister(ra, seen);
		checkCount++;
		if (seen !== expected) begin
			errorCount++;
			$display("Error at %0t ns: ldi R%0d is %h, expected %h", $time, ra, seen, expected);
		end
	endtask

	// Store through one base, load back through another so an address error shows
	task automatic storeLoadTest(input int index);
		logic [3:0] src;
		logic [3:0] dst;
		logic [3:0] base;
		logic [3:0] loadBase;
		logic [18:0] c;
		logic [18:0] loadC;
		word target;
		word address;
		word stored;
		word seen;
		src = 4'($urandom_range(15, 0));
		dst = src + 4'($urandom_range(15, 1)); // Never equal to src
		base = (index % 4 == 0) ? 4'd0 : 4'($urandom_range(15, 1));
		if (base == 0)
			setRegister(4'd0, $urandom | 1); // Nonzero R0 that BAout has to hide
		setRegister(src, $urandom);
		if (base != 0)
			setRegister(base, $urandom_range(ramDepth / 2 - 1, 0));
		// Data lives in the upper half, programs in the lower half
		target = ramDepth / 2 + $urandom_range(ramDepth / 2 - 1, 0);
		c = 19'(target - ((base == 0) ? '0 : regModel[base]));
		address = ((base == 0) ? '0 : regModel[base]) + signExtend(c);
		stored = regModel[src];
		fetchInstruction(encode(srcPkg::opSt, src, base, c));
		addressSteps();
		step(zLowOut | marIn);
		step(gra | rOut | mdrIn);
		step(ramWrite);
		ramModel[address[ramAddressWidth-1:0]] = stored;
		// Absolute load after a based store, based load after an absolute one
		loadBase = (base == 0) ? 4'($urandom_range(15, 1)) : 4'd0;
		if (loadBase != 0)
			setRegister(loadBase, $urandom_range(ramDepth / 2 - 1, 0));
		loadC = 19'(address - ((loadBase == 0) ? '0 : regModel[loadBase]));
		fetchInstruction(encode(srcPkg::opLd, dst, loadBase, loadC));
		addressSteps();
		step(zLowOut | marIn);
		step(mdMuxRead | ramRead | mdrIn);
		step(mdrOut | gra | rIn);
		regModel[dst] = ramModel[address[ramAddressWidth-1:0]];
		readRegister(dst, seen);
		checkCount++;
		if (seen !== stored) begin
			errorCount++;
			$display("Error at %0t ns: ld R%0d from %0d is %h, stored %h", $time, dst,
				address[ramAddressWidth-1:0], seen, stored);
		end
	endtask

	task automatic aluTest();
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] rc;
		logic [4:0] op;
		strobeVec opMask;
		int opIndex;
		word expected;
		word seen;
		ra = 4'($urandom_range(15, 0));
		rb = 4'($urandom_range(15, 0));
		rc = 4'($urandom_range(15, 0));
		opIndex = $urandom_range(7, 0);
		case (opIndex)
			0: op = srcPkg::opAdd;
			1: op = srcPkg::opSub;
			2: op = srcPkg::opAnd;
			3: op = srcPkg::opOr;
			4: op = srcPkg::opShl;
			5: op = srcPkg::opShr;
			6: op = srcPkg::opNeg;
			default: op = srcPkg::opNot;
		endcase
		case (opIndex)
			0: opMask = aluAdd;
			1: opMask = aluSub;
			2: opMask = aluAnd;
			3: opMask = aluOr;
			4: opMask = aluShl;
			5: opMask = aluShr;
			6: opMask = aluNeg;
			default: opMask = aluNot;
		endcase
		setRegister(rb, $urandom);
		setRegister(rc, $urandom);
		if (opIndex < 6) begin
			expected = aluExpected(opIndex, regModel[rb], regModel[rc]);
			fetchInstruction(encode(op, ra, rb, {rc, 15'd0})); // rc on top of C
			step(grb | rOut | yIn);
			step(grc | rOut | opMask | zLowIn);
		end else begin
			expected = aluExpected(opIndex, '0, regModel[rb]);
			fetchInstruction(encode(op, ra, rb, 19'd0));
			step(grb | rOut | opMask | zLowIn);
		end
		step(zLowOut | gra | rIn);
		regModel[ra] = expected;
		readRegister(ra, seen);
		checkCount++;
		if (seen !== expected) begin
			errorCount++;
			$display("Error at %0t ns: ALU op %0d R%0d is %h, expected %h", $time, opIndex, ra,
				seen, expected);
		end
	endtask

	task automatic conditionTest(input int index);
		logic [3:0] cond;
		word value;
		cond = (index % 5 < 4) ? 4'(index % 5) : 4'($urandom_range(15, 4)); // Some unknown codes
		value = ($urandom_range(3, 0) == 0) ? '0 : $urandom;
		stepData(inPortOut | irIn, encode(srcPkg::opBranch, 4'($urandom_range(15, 0)), cond,
			19'd0));
		stepData(inPortOut | conIn, value);
		settle();
		checkCount++;
		if (conFF !== condExpected(cond, value)) begin
			errorCount++;
			$display("Error at %0t ns: conFF is %b for cond %0d and bus %h", $time, conFF, cond,
				value);
		end
	endtask

	// Reset in the middle of a run, with out-port and flag set
	task automatic resetTest();
		logic [3:0] r;
		word seen;
		r = 4'($urandom_range(15, 0));
		setRegister(r, $urandom | 1);
		readRegister(r, seen);
		stepData(inPortOut | irIn, encode(srcPkg::opBranch, 4'd0, srcPkg::condNonzero, 19'd0));
		stepData(inPortOut | conIn, 32'd1);
		@(posedge clock);
		strobes <= '0;
		reset <= 1'b1;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		for (int i = 0; i < srcPkg::registerCount; i++)
			regModel[i] = '0;
		pcModel = '0;
		ramModel[0] = '0; // Only word 0 is cleared
		checkCount += 2;
		if (outPortData !== '0) begin
			errorCount++;
			$display("Error at %0t ns: out-port is %h after reset", $time, outPortData);
		end
		if (conFF !== 1'b0) begin
			errorCount++;
			$display("Error at %0t ns: conFF is %b after reset", $time, conFF);
		end
		readRegister(r, seen);
		checkCount++;
		if (seen !== '0) begin
			errorCount++;
			$display("Error at %0t ns: R%0d is %h after reset", $time, r, seen);
		end
	endtask

	initial begin
		void'($urandom(90));
		clock = 1'b0;
		reset = 1'b1;
		strobes = '0;
		inPortData = '0;
		errorCount = 0;
		checkCount = 0;
		pcModel = '0;
		for (int i = 0; i < srcPkg::registerCount; i++)
			regModel[i] = '0;
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		repeat (ldiCount) ldiTest();
		for (int i = 0; i < stLdCount; i++)
			storeLoadTest(i);
		resetTest();
		repeat (aluCount) aluTest();
		for (int i = 0; i < condCount; i++)
			conditionTest(i);
		settle();
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// Watchdog, cycle budget plus ten percent
	initial begin
		#(totalSteps * 110);
		$display("Timeout: the run did not finish within %0d cycles", totalSteps);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim.f
source/srcPkg.sv
source/selectEncode.sv
source/registerFile.sv
source/arithUnit.sv
source/memoryInterface.sv
source/conditionFlag.sv
source/datapath.sv
dv/datapath_checker.sv
dv/datapathTb.sv

//--- Bender.yml
package:
  name: datapath

sources:
  - source/srcPkg.sv
  - source/selectEncode.sv
  - source/registerFile.sv
  - source/arithUnit.sv
  - source/memoryInterface.sv
  - source/conditionFlag.sv
  - source/datapath.sv
  - target: test
    files:
      - dv/datapath_checker.sv
      - dv/datapathTb.sv
